/* include/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////
// fetch stage widths

// address width, also the width of the bus read data
`define FETCH_XLEN 64

// width of one uncompressed instruction
`define FETCH_ILEN 32

////////////////////
// boot

// first pc requested once reset is released
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

`endif

/* src/fetch_pkg.sv */
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

	typedef enum logic [1:0] {
		KIND_PLAIN,                          // falls through to the next pc
		KIND_JAL,                            // direct jump, always taken
		KIND_JALR,                           // target known only after execute
		KIND_BRANCH                          // conditional, resolved by the bru
	} instr_kind_e;

	typedef enum logic [6:0] {
		OPC_BRANCH = 7'b110_0011,
		OPC_JALR   = 7'b110_0111,
		OPC_JAL    = 7'b110_1111
	} opcode_e;

	// compressed ops keyed by {funct3, quadrant}
	typedef enum logic [4:0] {
		RVC_JR   = 5'b100_10,                // c.jr and c.jalr
		RVC_J    = 5'b101_01,
		RVC_BEQZ = 5'b110_01,
		RVC_BNEZ = 5'b111_01
	} rvc_op_e;

	typedef struct packed {
		instr_kind_e             kind;
		logic                    is_rvc;
		logic [`FETCH_XLEN-1:0]  imm;        // sign extended jump offset
	} predecode_t;

	typedef struct packed {
		logic                    jalr_valid;
		logic [`FETCH_XLEN-1:0]  jalr_pc;
		logic                    bru_res_valid;
		logic                    bru_taken;
	} redirect_t;

	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic [`FETCH_XLEN-1:0]  adr;        // half-word aligned fetch address
	} wb_req_t;

	typedef struct packed {
		logic                    ack;
		logic [`FETCH_XLEN-1:0]  dat;        // 64 bits starting at adr
	} wb_rsp_t;

	typedef enum logic [1:0] {IFU_IDLE, IFU_BUS, IFU_FULL} ifu_state_e;

	typedef enum logic [1:0] {BP_RUN, BP_WAIT_BRU, BP_WAIT_JALR} bp_state_e;

endpackage

`default_nettype wire

/* src/pre_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module pre_decode (
	input  wire [`FETCH_ILEN-1:0]   instr,
	output fetch_pkg::predecode_t   pd
);

	logic                   is_rvc;
	logic [`FETCH_XLEN-1:0] imm_j;                 // jal
	logic [`FETCH_XLEN-1:0] imm_b;                 // beq and friends
	logic [`FETCH_XLEN-1:0] imm_cj;                // c.j
	logic [`FETCH_XLEN-1:0] imm_cb;                // c.beqz / c.bnez
	logic                   cjr_ok;                // rs1 set and rs2 zero

	assign is_rvc = (instr[1:0] != 2'b11);        // 32-bit ops end in 11

	////////////////////
	// immediates

	assign imm_j = {{(`FETCH_XLEN-20){instr[31]}}, instr[19:12], instr[20],
		instr[30:21], 1'b0};
	assign imm_b = {{(`FETCH_XLEN-12){instr[31]}}, instr[7], instr[30:25],
		instr[11:8], 1'b0};
	assign imm_cj = {{(`FETCH_XLEN-11){instr[12]}}, instr[8], instr[10:9],
		instr[6], instr[7], instr[2], instr[11], instr[5:3], 1'b0};
	assign imm_cb = {{(`FETCH_XLEN-8){instr[12]}}, instr[6:5], instr[2],
		instr[11:10], instr[4:3], 1'b0};

	// c.jr / c.jalr need rs1 != 0 and rs2 == 0, else it is c.mv, c.add or ebreak
	assign cjr_ok = (instr[11:7] != 5'd0) && (instr[6:2] == 5'd0);

	////////////////////
	// classify

	always_comb begin
		pd.kind   = fetch_pkg::KIND_PLAIN;         // default fall through
		pd.is_rvc = is_rvc;
		pd.imm    = '0;
		if (is_rvc) begin
			case ({instr[15:13], instr[1:0]})
				fetch_pkg::RVC_J: begin
					pd.kind = fetch_pkg::KIND_JAL;    // no link on c.j
					pd.imm  = imm_cj;
				end
				fetch_pkg::RVC_BEQZ, fetch_pkg::RVC_BNEZ: begin
					pd.kind = fetch_pkg::KIND_BRANCH;
					pd.imm  = imm_cb;
				end
				fetch_pkg::RVC_JR: begin
					if (cjr_ok) begin
						pd.kind = fetch_pkg::KIND_JALR; // c.jalr lands here too
					end
				end
				default: ;                            // c.jal does not exist on rv64
			endcase
		end else begin
			case (instr[6:0])
				fetch_pkg::OPC_JAL: begin
					pd.kind = fetch_pkg::KIND_JAL;
					pd.imm  = imm_j;
				end
				fetch_pkg::OPC_JALR: begin
					pd.kind = fetch_pkg::KIND_JALR;   // target comes from execute
				end
				fetch_pkg::OPC_BRANCH: begin
					pd.kind = fetch_pkg::KIND_BRANCH;
					pd.imm  = imm_b;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/branch_predict.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module branch_predict (
	input  wire                         CLK,
	input  wire                         rst_n,
	input  wire fetch_pkg::predecode_t  pd,
	input  wire                         handoff,
	input  wire fetch_pkg::redirect_t   redirect,
	input  wire                         privileged_valid,
	input  wire [`FETCH_XLEN-1:0]       privileged_pc,
	output logic [`FETCH_XLEN-1:0]      fetch_pc,
	output logic                        pc_req,
	output logic                        flush,
	output logic                        is_mispredict
);

	fetch_pkg::bp_state_e   state;
	logic [`FETCH_XLEN-1:0] alt_pc;                // pc on the side not predicted
	logic                   pred_taken;            // prediction of the open branch
	logic [`FETCH_XLEN-1:0] seq_pc;
	logic [`FETCH_XLEN-1:0] tgt_pc;
	logic                   backward;
	logic                   bru_done;
	logic                   jalr_done;
	logic                   run_handoff;

	////////////////////
	// next pc candidates

	assign seq_pc   = fetch_pc + (pd.is_rvc ? `FETCH_XLEN'(2) : `FETCH_XLEN'(4));
	assign tgt_pc   = fetch_pc + pd.imm;
	assign backward = pd.imm[`FETCH_XLEN-1];      // negative offset means a loop

	assign bru_done    = (state == fetch_pkg::BP_WAIT_BRU) && redirect.bru_res_valid;
	assign jalr_done   = (state == fetch_pkg::BP_WAIT_JALR) && redirect.jalr_valid;
	assign run_handoff = (state == fetch_pkg::BP_RUN) && handoff;

	// raised in the very cycle the bru answer comes back
	assign is_mispredict = bru_done && (redirect.bru_taken != pred_taken);

	////////////////////
	// pc register and fsm

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state      <= fetch_pkg::BP_RUN;
			fetch_pc   <= `FETCH_RESET_PC;
			pc_req     <= 1'b1;                       // kick off the boot fetch
			flush      <= 1'b0;
			pred_taken <= 1'b0;
		end else begin
			pc_req <= 1'b0;                           // one cycle pulse by default
			flush  <= privileged_valid;
			if (privileged_valid) begin               // trap or return wins always
				fetch_pc <= {privileged_pc[`FETCH_XLEN-1:1], 1'b0};
				state    <= fetch_pkg::BP_RUN;
				pc_req   <= 1'b1;
			end else if (bru_done) begin
				if (is_mispredict) begin
					fetch_pc <= alt_pc;                 // take the other side
				end
				state  <= fetch_pkg::BP_RUN;
				pc_req <= 1'b1;
			end else if (jalr_done) begin
				fetch_pc <= {redirect.jalr_pc[`FETCH_XLEN-1:1], 1'b0};
				state    <= fetch_pkg::BP_RUN;
				pc_req   <= 1'b1;
			end else if (run_handoff) begin
				case (pd.kind)
					fetch_pkg::KIND_JAL: begin
						fetch_pc <= tgt_pc;
						pc_req   <= 1'b1;
					end
					fetch_pkg::KIND_BRANCH: begin
						fetch_pc   <= backward ? tgt_pc : seq_pc;
						pred_taken <= backward;
						state      <= fetch_pkg::BP_WAIT_BRU;  // hold until resolved
					end
					fetch_pkg::KIND_JALR: begin
						state <= fetch_pkg::BP_WAIT_JALR;    // target unknown yet
					end
					default: begin
						fetch_pc <= seq_pc;
						pc_req   <= 1'b1;
					end
				endcase
			end
		end
	end

	// recovery pc for the open branch
	always_ff @(posedge CLK) begin
		if (run_handoff && (pd.kind == fetch_pkg::KIND_BRANCH)) begin
			alt_pc <= backward ? seq_pc : tgt_pc;
		end
	end

	////////////////////
	// checks

	// one unresolved control transfer at most, so nothing is fetched while waiting
	a_no_req_in_wait: assert property (@(posedge CLK) disable iff (!rst_n)
		(state != fetch_pkg::BP_RUN) |-> !pc_req);

	a_pc_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
		!fetch_pc[0]);

endmodule

`default_nettype wire

/* src/ifu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module ifu (
	input  wire                       CLK,
	input  wire                       rst_n,
	input  wire [`FETCH_XLEN-1:0]     fetch_pc,
	input  wire                       pc_req,
	input  wire                       flush,
	input  wire fetch_pkg::wb_rsp_t   wb_rsp,
	input  wire                       instr_ready,
	output fetch_pkg::wb_req_t        wb_req,
	output logic [`FETCH_ILEN-1:0]    instr,
	output logic                      instr_valid,
	output logic                      handoff
);

	fetch_pkg::ifu_state_e  state;
	logic [`FETCH_XLEN-1:0] adr_q;                 // address of the bus cycle
	logic                   req_pend;              // pc_req seen while busy
	logic                   drop;                  // response belongs to old path
	logic                   start;
	logic                   bus_act;
	logic                   ack_ok;

	assign start   = (state == fetch_pkg::IFU_IDLE) && (pc_req || req_pend);
	assign bus_act = (state == fetch_pkg::IFU_BUS);
	assign ack_ok  = bus_act && wb_rsp.ack;

	////////////////////
	// wishbone master

	always_comb begin
		wb_req.cyc = bus_act;                       // classic cycle, no bursts
		wb_req.stb = bus_act;
		wb_req.adr = adr_q;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state    <= fetch_pkg::IFU_IDLE;
			req_pend <= 1'b0;
			drop     <= 1'b0;
		end else begin
			case (state)
				fetch_pkg::IFU_IDLE: begin
					drop <= 1'b0;
					if (start) begin
						state <= fetch_pkg::IFU_BUS;     // stb the cycle after pc_req
					end
				end
				fetch_pkg::IFU_BUS: begin
					if (wb_rsp.ack) begin
						// stale data goes nowhere
						state <= (drop || flush) ? fetch_pkg::IFU_IDLE : fetch_pkg::IFU_FULL;
						drop  <= 1'b0;
					end else if (flush) begin
						drop <= 1'b1;                       // let the cycle finish
					end
				end
				fetch_pkg::IFU_FULL: begin
					if (flush || handoff) begin
						state <= fetch_pkg::IFU_IDLE;
					end
				end
				default: state <= fetch_pkg::IFU_IDLE;
			endcase
			if (start) begin
				req_pend <= 1'b0;
			end else if (pc_req) begin
				req_pend <= 1'b1;                       // served once the bus is free
			end
		end
	end

	////////////////////
	// instruction buffer

	always_ff @(posedge CLK) begin
		if (start) begin
			adr_q <= fetch_pc;                        // pc is held until handoff
		end
		if (ack_ok) begin
			instr <= wb_rsp.dat[`FETCH_ILEN-1:0];     // slave aligns to the half-word
		end
	end

	assign instr_valid = (state == fetch_pkg::IFU_FULL) && !flush;  // hide a killed entry
	assign handoff     = instr_valid && instr_ready;

	////////////////////
	// checks

	// the slave may only ack inside an open strobed cycle
	a_ack_in_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb));

	// a waiting request keeps stb and adr until the slave acks
	a_adr_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		(wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)));

endmodule

`default_nettype wire

/* src/pc_generate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module pc_generate (
	input  wire                        CLK,
	input  wire                        rst_n,
	input  wire fetch_pkg::redirect_t  redirect,          // jalr and bru results
	input  wire                        privileged_valid,  // from commit
	input  wire [`FETCH_XLEN-1:0]      privileged_pc,
	input  wire fetch_pkg::wb_rsp_t    wb_rsp,
	input  wire                        instr_ready,       // decode can take one
	output fetch_pkg::wb_req_t         wb_req,
	output logic [`FETCH_XLEN-1:0]     fetch_pc,
	output logic [`FETCH_ILEN-1:0]     instr,
	output logic                       is_rvc,
	output logic                       instr_valid,
	output logic                       is_mispredict      // to commit
);

	logic                  pc_req;
	logic                  flush;
	logic                  handoff;
	fetch_pkg::predecode_t pd;

	ifu ifu0 (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.fetch_pc    (fetch_pc),
		.pc_req      (pc_req),
		.flush       (flush),
		.wb_rsp      (wb_rsp),
		.instr_ready (instr_ready),
		.wb_req      (wb_req),
		.instr       (instr),
		.instr_valid (instr_valid),
		.handoff     (handoff)
	);

	pre_decode pre_decode0 (
		.instr (instr),
		.pd    (pd)
	);

	branch_predict branch_predict0 (
		.CLK              (CLK),
		.rst_n            (rst_n),
		.pd               (pd),
		.handoff          (handoff),
		.redirect         (redirect),
		.privileged_valid (privileged_valid),
		.privileged_pc    (privileged_pc),
		.fetch_pc         (fetch_pc),
		.pc_req           (pc_req),
		.flush            (flush),
		.is_mispredict    (is_mispredict)
	);

	assign is_rvc = pd.is_rvc;                      // length bit straight to decode

endmodule

`default_nettype wire

/* tests/wb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module wb_mem_model (
	input  wire                      CLK,
	input  wire                      rst_n,
	input  wire fetch_pkg::wb_req_t  wb_req,
	output fetch_pkg::wb_rsp_t       wb_rsp
);

	logic [15:0]            mem [512];         // half-words, aliased every 1 KiB
	logic                   start_tab [512];   // an instruction begins here
	logic                   rvc_tab [512];
	fetch_pkg::instr_kind_e kind_tab [512];
	logic [`FETCH_XLEN-1:0] off_tab [512];     // byte offset of jal and branch
	logic [1:0]             wait_cnt;          // cycles left before the next ack
	logic [8:0]             a;

	assign a = wb_req.adr[9:1];

	// random program whose jump targets always land on an instruction start
	task automatic fill_program();
		int          i;
		int          n;
		int          t;
		int          k;
		logic [8:0]  ix;
		logic [63:0] off;
		logic [31:0] w;
		logic [15:0] h;
		for (i = 0; i < 512; i++) begin
			start_tab[9'(i)] = 1'b0;
		end
		n = 0;
		while (n < 512) begin                      // lay out the lengths first
			start_tab[9'(n)] = 1'b1;
			rvc_tab[9'(n)] = (n == 511) || ($urandom_range(1, 0) == 1);
			n = rvc_tab[9'(n)] ? n + 1 : n + 2;
		end
		for (i = 0; i < 512; i++) begin
			ix = 9'(i);
			if (start_tab[ix]) begin
				t = (i + $urandom_range(60, 0) - 30) & 511;
				while (!start_tab[9'(t)]) begin
					t = (t + 1) & 511;                   // snap to the next start
				end
				n = (t - i + 512) % 512;
				if (n >= 256) begin
					n = n - 512;                         // short backward jump
				end
				off = longint'(2 * n);
				k = $urandom_range(9, 0);
				w = {25'($urandom), 7'b011_0011};      // plain alu op
				h = {14'($urandom), 2'b00};            // quadrant 0, never control flow
				kind_tab[ix] = fetch_pkg::KIND_PLAIN;
				case (k)
					5, 6: begin
						kind_tab[ix] = fetch_pkg::KIND_JAL;
						w = {off[20], off[10:1], off[11], off[19:12], 5'($urandom), 7'b110_1111};
						h = {3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7],
							off[3:1], off[5], 2'b01};      // c.j
					end
					7, 8: begin
						kind_tab[ix] = fetch_pkg::KIND_BRANCH;
						w = {off[12], off[10:5], 10'($urandom), 3'($urandom), off[4:1],
							off[11], 7'b110_0011};
						h = {2'b11, 1'($urandom), off[8], off[4:3], 3'($urandom), off[7:6],
							off[2:1], off[5], 2'b01};      // c.beqz or c.bnez
					end
					9: begin
						kind_tab[ix] = fetch_pkg::KIND_JALR;
						w = {12'($urandom), 5'($urandom), 3'b000, 5'($urandom), 7'b110_0111};
						h = {3'b100, 1'($urandom), 5'($urandom_range(31, 1)), 5'd0, 2'b10};
					end
					default: ;
				endcase
				off_tab[ix] = off;
				mem[ix] = rvc_tab[ix] ? h : w[15:0];
				if (!rvc_tab[ix]) begin
					mem[ix + 9'd1] = w[31:16];
				end
			end
		end
	endtask

	////////////////////
	// slave side

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_rsp   <= '0;
			wait_cnt <= 2'd0;
		end else if (wb_rsp.ack) begin
			wb_rsp.ack <= 1'b0;                        // single cycle ack
		end else if (wb_req.cyc && wb_req.stb) begin
			if (wait_cnt == 2'd0) begin
				wb_rsp.ack <= 1'b1;
				wb_rsp.dat <= {mem[a + 9'd3], mem[a + 9'd2], mem[a + 9'd1], mem[a]};
				wait_cnt   <= 2'($urandom_range(3, 0));  // delay of the next cycle
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_pc_generate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module tb_pc_generate;

	logic                   CLK;
	logic                   rst_n;
	fetch_pkg::redirect_t   redirect;
	logic                   privileged_valid;
	logic [`FETCH_XLEN-1:0] privileged_pc;
	fetch_pkg::wb_req_t     wb_req;
	fetch_pkg::wb_rsp_t     wb_rsp;
	logic                   instr_ready;
	logic [`FETCH_XLEN-1:0] fetch_pc;
	logic [`FETCH_ILEN-1:0] instr;
	logic                   is_rvc;
	logic                   instr_valid;
	logic                   is_mispredict;

	fetch_pkg::bp_state_e   m_state;             // next-pc model
	logic [`FETCH_XLEN-1:0] m_pc;
	logic [`FETCH_XLEN-1:0] m_alt;               // pc on the unpredicted side
	logic                   m_pred;
	logic [`FETCH_XLEN-1:0] pc_before;           // model pc before the last edge
	int                     resp_wait;           // cycles until execute answers
	int                     handoffs;
	int                     idle_cycles;
	logic                   first_req;
	logic                   prev_stb;
	logic                   prev_ack;
	logic                   prev_hold;           // valid and stalled last cycle
	logic [`FETCH_ILEN-1:0] prev_instr;
	logic [`FETCH_XLEN-1:0] prev_pc;

	pc_generate dut0 (
		.CLK              (CLK),
		.rst_n            (rst_n),
		.redirect         (redirect),
		.privileged_valid (privileged_valid),
		.privileged_pc    (privileged_pc),
		.wb_rsp           (wb_rsp),
		.instr_ready      (instr_ready),
		.wb_req           (wb_req),
		.fetch_pc         (fetch_pc),
		.instr            (instr),
		.is_rvc           (is_rvc),
		.instr_valid      (instr_valid),
		.is_mispredict    (is_mispredict)
	);

	wb_mem_model mem0 (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [63:0] pick_target();
		logic [8:0] ix;
		ix = 9'($urandom);
		while (!mem0.start_tab[ix]) begin
			ix = ix + 9'd1;
		end
		return `FETCH_RESET_PC + {53'd0, ix, 1'b0};
	endfunction

	task automatic drive_inputs();
		instr_ready      = ($urandom_range(3, 0) != 0);
		privileged_valid = ($urandom_range(199, 0) == 0);  // rare trap
		privileged_pc    = pick_target();
		redirect         = '0;
		if (m_state != fetch_pkg::BP_RUN) begin
			if (resp_wait == 0) begin
				redirect.bru_res_valid = (m_state == fetch_pkg::BP_WAIT_BRU);
				redirect.bru_taken     = 1'($urandom);
				redirect.jalr_valid    = (m_state == fetch_pkg::BP_WAIT_JALR);
				redirect.jalr_pc       = pick_target();
			end else begin
				resp_wait--;
			end
		end
	endtask

	////////////////////
	// checks, sampled just before the rising edge

	task automatic check_cycle();
		logic [8:0] a;
		logic       exp_misp;
		a = m_pc[9:1];
		if (wb_req.stb && !prev_stb) begin
			expect_equal(wb_req.adr, pc_before, "bus request address");
			if (first_req) begin
				expect_equal(wb_req.adr, `FETCH_RESET_PC, "first request after reset");
				first_req = 1'b0;
			end
		end
		if (prev_ack) begin
			expect_equal(64'(wb_req.stb || wb_req.cyc), 64'd0, "cycle dropped after ack");
		end
		if (prev_hold) begin
			expect_equal(64'(instr_valid), 64'd1, "instr_valid under back-pressure");
			expect_equal(64'(instr), 64'(prev_instr), "instr under back-pressure");
			expect_equal(fetch_pc, prev_pc, "fetch_pc under back-pressure");
		end
		exp_misp = (m_state == fetch_pkg::BP_WAIT_BRU) && redirect.bru_res_valid &&
			(redirect.bru_taken != m_pred);
		expect_equal(64'(is_mispredict), 64'(exp_misp), "is_mispredict");
		if (instr_valid && instr_ready) begin
			expect_equal(fetch_pc, m_pc, "fetch_pc at handoff");
			expect_equal(64'(instr), 64'({mem0.mem[a + 9'd1], mem0.mem[a]}), "instr at handoff");
			expect_equal(64'(is_rvc), 64'(mem0.rvc_tab[a]), "is_rvc at handoff");
		end
		prev_stb   = wb_req.stb;
		prev_ack   = wb_rsp.ack;
		prev_hold  = instr_valid && !instr_ready && !privileged_valid;
		prev_instr = instr;
		prev_pc    = fetch_pc;
	endtask

	task automatic update_model();
		logic [8:0]  a;
		logic [63:0] seq;
		logic [63:0] tgt;
		logic        back;
		a         = m_pc[9:1];
		seq       = m_pc + (mem0.rvc_tab[a] ? 64'd2 : 64'd4);
		tgt       = m_pc + mem0.off_tab[a];
		back      = mem0.off_tab[a][63];            // backward means predicted taken
		pc_before = m_pc;
		if (instr_valid && instr_ready) begin
			handoffs++;
			idle_cycles = 0;
		end
		if (privileged_valid) begin
			m_pc    = privileged_pc;
			m_state = fetch_pkg::BP_RUN;
		end else if ((m_state == fetch_pkg::BP_WAIT_BRU) && redirect.bru_res_valid) begin
			if (redirect.bru_taken != m_pred) begin
				m_pc = m_alt;
			end
			m_state = fetch_pkg::BP_RUN;
		end else if ((m_state == fetch_pkg::BP_WAIT_JALR) && redirect.jalr_valid) begin
			m_pc    = redirect.jalr_pc;
			m_state = fetch_pkg::BP_RUN;
		end else if ((m_state == fetch_pkg::BP_RUN) && instr_valid && instr_ready) begin
			case (mem0.kind_tab[a])
				fetch_pkg::KIND_JAL: m_pc = tgt;
				fetch_pkg::KIND_BRANCH: begin
					m_pred    = back;
					m_pc      = back ? tgt : seq;
					m_alt     = back ? seq : tgt;
					m_state   = fetch_pkg::BP_WAIT_BRU;
					resp_wait = $urandom_range(4, 0);
				end
				fetch_pkg::KIND_JALR: begin
					m_state   = fetch_pkg::BP_WAIT_JALR;
					resp_wait = $urandom_range(4, 0);
				end
				default: m_pc = seq;
			endcase
		end
	endtask

	////////////////////
	// main sequence

	initial begin
		void'($urandom(32'h9925));
		rst_n            = 1'b0;
		redirect         = '0;
		privileged_valid = 1'b0;
		privileged_pc    = '0;
		instr_ready      = 1'b0;
		m_state          = fetch_pkg::BP_RUN;
		m_pc             = `FETCH_RESET_PC;
		m_alt            = '0;
		m_pred           = 1'b0;
		pc_before        = `FETCH_RESET_PC;
		resp_wait        = 0;
		handoffs         = 0;
		idle_cycles      = 0;
		first_req        = 1'b1;
		prev_stb         = 1'b0;
		prev_ack         = 1'b0;
		prev_hold        = 1'b0;
		prev_instr       = '0;
		prev_pc          = '0;
		mem0.fill_program();
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		while (handoffs < 2000) begin
			drive_inputs();
			#1;
			check_cycle();
			update_model();
			idle_cycles++;
			if (idle_cycles > 300) begin
				$display("timeout: no instruction reached decode for 300 cycles at %0t", $time);
				$display("Test FAILED");
				$fatal(1, "handoff timeout");
			end
			@(negedge CLK);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
src/fetch_pkg.sv
src/pre_decode.sv
src/branch_predict.sv
src/ifu.sv
src/pc_generate.sv
tests/wb_mem_model.sv
tests/tb_pc_generate.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pc generation testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_pc_generate -o sim_pc_generate
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_pc_generate
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

exit 0
